// File: axi2per_checker.sv
module axi2per_checker #(
  parameter int unsigned AXI_ID_WIDTH = 4
) (
  input logic                    clk_i,
  input logic                    rst_ni,
  input logic                    r_valid_o,
  input axi2per_pkg::axi_data_t  r_data_o,
  input logic                    r_last_o,
  input logic [AXI_ID_WIDTH-1:0] r_id_o,
  input logic                    r_ready_i,
  input logic                    b_valid_o,
  input logic [AXI_ID_WIDTH-1:0] b_id_o,
  input logic                    b_ready_i
);

  // Failed assertions, read by the testbench at the end
  int unsigned fail_count = 0;

  // R held with stable payload until the master takes it
  r_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_data_o) && $stable(r_id_o))
  else begin
    fail_count++;
    $error("R valid or payload changed before ready");
  end

  // Same rule on B
  b_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    b_valid_o && !b_ready_i |=> b_valid_o && $stable(b_id_o))
  else begin
    fail_count++;
    $error("B valid or ID changed before ready");
  end

  // One transaction at a time, so never both
  r_b_excl_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(r_valid_o && b_valid_o))
  else begin
    fail_count++;
    $error("R and B valid high together");
  end

  // Single-beat reads
  r_last_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    r_last_o == r_valid_o)
  else begin
    fail_count++;
    $error("R last differs from R valid");
  end

endmodule

bind axi2per_top axi2per_checker #(
  .AXI_ID_WIDTH (AXI_ID_WIDTH)
) i_checker (
  .clk_i     (clk_i),
  .rst_ni    (rst_ni),
  .r_valid_o (r_valid_o),
  .r_data_o  (r_data_o),
  .r_last_o  (r_last_o),
  .r_id_o    (r_id_o),
  .r_ready_i (r_ready_i),
  .b_valid_o (b_valid_o),
  .b_id_o    (b_id_o),
  .b_ready_i (b_ready_i)
);

// File: axi2per_pkg.sv
package axi2per_pkg;

  // ********************
  // AXI side
  // ********************

  // Byte address carried on AR and AW
  typedef logic [31:0] axi_addr_t;

  // One 64-bit beat on W and R
  // Bit 2 of the address picks the 32-bit half in use
  typedef logic [63:0] axi_data_t;

  // One strobe per byte of the AXI beat
  typedef logic [7:0] axi_strb_t;

  // Response code on R and B
  typedef logic [1:0] axi_resp_t;

  // ********************
  // Peripheral side
  // ********************

  // Byte address on the peripheral bus
  // Bits [1:0] are ignored by the targets
  typedef logic [31:0] per_addr_t;

  // One 32-bit peripheral word
  typedef logic [31:0] per_data_t;

  // ********************
  // Response codes
  // ********************

  // No SLVERR or DECERR, every access completes as OKAY
  localparam axi_resp_t RESP_OKAY = 2'b00;

endpackage

// File: axi2per_req_channel.sv
module axi2per_req_channel #(
  parameter int unsigned AXI_ID_WIDTH = 4
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,

  // AXI write address channel
  input  logic                    aw_valid_i,
  input  axi2per_pkg::axi_addr_t  aw_addr_i,
  input  logic [AXI_ID_WIDTH-1:0] aw_id_i,
  output logic                    aw_ready_o,

  // AXI write data channel
  input  logic                    w_valid_i,
  input  axi2per_pkg::axi_data_t  w_data_i,
  input  axi2per_pkg::axi_strb_t  w_strb_i,
  output logic                    w_ready_o,

  // AXI read address channel
  input  logic                    ar_valid_i,
  input  axi2per_pkg::axi_addr_t  ar_addr_i,
  input  logic [AXI_ID_WIDTH-1:0] ar_id_i,
  output logic                    ar_ready_o,

  // Peripheral request
  output logic                    per_req_o,
  output axi2per_pkg::per_addr_t  per_add_o,
  output logic                    per_wen_o,
  output logic [3:0]              per_be_o,
  output axi2per_pkg::per_data_t  per_wdata_o,
  input  logic                    per_gnt_i,

  // Transaction info towards the response channel
  output logic                    trans_req_o,
  output logic                    trans_wen_o,
  output logic [AXI_ID_WIDTH-1:0] trans_id_o,
  output axi2per_pkg::axi_addr_t  trans_add_o,
  input  logic                    trans_done_i
);

  import axi2per_pkg::*;

  typedef enum logic [1:0] {Idle, Request, WaitResponse} state_e;

  state_e state_d, state_q;

  // A write needs AW and W together, and it wins over AR
  logic write_go;
  logic read_go;
  logic accept;

  // Request picked in the accept cycle
  axi_addr_t               sel_addr;
  logic [AXI_ID_WIDTH-1:0] sel_id;
  per_data_t               sel_wdata;
  logic [3:0]              sel_be;

  // Buffered request, held until the response is out
  logic                    wen_q;
  axi_addr_t               addr_q;
  logic [AXI_ID_WIDTH-1:0] id_q;
  per_data_t               wdata_q;
  logic [3:0]              be_q;

  assign write_go = aw_valid_i & w_valid_i;
  assign read_go  = ar_valid_i & ~write_go;
  assign accept   = (state_q == Idle) & (write_go | read_go);

  // Ready only in idle, and only for the channel that is taken
  assign aw_ready_o = (state_q == Idle) & write_go;
  assign w_ready_o  = (state_q == Idle) & write_go;
  assign ar_ready_o = (state_q == Idle) & read_go;

  // ********************
  // Request select
  // ********************
  always_comb begin
    if (write_go) begin
      sel_addr = aw_addr_i;
      sel_id   = aw_id_i;
      // Address bit 2 picks the upper or lower half of the beat
      if (aw_addr_i[2]) begin
        sel_wdata = w_data_i[63:32];
        sel_be    = w_strb_i[7:4];
      end else begin
        sel_wdata = w_data_i[31:0];
        sel_be    = w_strb_i[3:0];
      end
    end else begin
      sel_addr  = ar_addr_i;
      sel_id    = ar_id_i;
      // Reads fetch the whole word
      sel_wdata = '0;
      sel_be    = 4'hf;
    end
  end

  // ********************
  // FSM
  // ********************
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      Idle: begin
        if (accept) begin
          state_d = Request;
        end
      end
      Request: begin
        // Request stays up until the target grants it
        if (per_gnt_i) begin
          state_d = WaitResponse;
        end
      end
      WaitResponse: begin
        // No new AXI request before R or B has gone out
        if (trans_done_i) begin
          state_d = Idle;
        end
      end
      default: state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
      wen_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        // Peripheral convention, 1 means read
        wen_q <= ~write_go;
      end
    end
  end

  // Payload of the accepted request
  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q  <= sel_addr;
      id_q    <= sel_id;
      wdata_q <= sel_wdata;
      be_q    <= sel_be;
    end
  end

  assign per_req_o   = (state_q == Request);
  assign per_add_o   = per_addr_t'(addr_q);
  assign per_wen_o   = wen_q;
  assign per_be_o    = be_q;
  assign per_wdata_o = wdata_q;

  // Info handed over in the grant cycle
  assign trans_req_o = per_req_o & per_gnt_i;
  assign trans_wen_o = wen_q;
  assign trans_id_o  = id_q;
  assign trans_add_o = addr_q;

endmodule

// File: axi2per_res_channel.sv
module axi2per_res_channel #(
  parameter int unsigned AXI_ID_WIDTH = 4
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,

  // Peripheral answer
  input  logic                    per_r_valid_i,
  input  axi2per_pkg::per_data_t  per_r_rdata_i,

  // Transaction info from the request channel
  input  logic                    trans_req_i,
  input  logic                    trans_wen_i,
  input  logic [AXI_ID_WIDTH-1:0] trans_id_i,
  input  axi2per_pkg::axi_addr_t  trans_add_i,
  output logic                    trans_done_o,

  // AXI read data channel
  output logic                    r_valid_o,
  output axi2per_pkg::axi_data_t  r_data_o,
  output axi2per_pkg::axi_resp_t  r_resp_o,
  output logic                    r_last_o,
  output logic [AXI_ID_WIDTH-1:0] r_id_o,
  input  logic                    r_ready_i,

  // AXI write response channel
  output logic                    b_valid_o,
  output axi2per_pkg::axi_resp_t  b_resp_o,
  output logic [AXI_ID_WIDTH-1:0] b_id_o,
  input  logic                    b_ready_i
);

  import axi2per_pkg::*;

  typedef enum logic {TransIdle, TransPending} state_e;

  state_e state_d, state_q;

  // Buffered transaction info with wen_q set for a read
  logic                    wen_q;
  logic                    half_q;
  logic [AXI_ID_WIDTH-1:0] id_q;

  // Peripheral data latched on the read-valid pulse
  per_data_t               rdata_q;

  logic                    handshake;

  // ********************
  // FSM
  // ********************
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      TransIdle: begin
        // Answer is latched whatever the ready lines do
        if (per_r_valid_i) begin
          state_d = TransPending;
        end
      end
      TransPending: begin
        if (handshake) begin
          state_d = TransIdle;
        end
      end
      default: state_d = TransIdle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= TransIdle;
      wen_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      if (trans_req_i) begin
        wen_q <= trans_wen_i;
      end
    end
  end

  // Transaction payload and read data
  always_ff @(posedge clk_i) begin
    if (trans_req_i) begin
      half_q <= trans_add_i[2];
      id_q   <= trans_id_i;
    end
    if (per_r_valid_i) begin
      rdata_q <= per_r_rdata_i;
    end
  end

  // ********************
  // R and B outputs
  // ********************

  // Valid held from pending until the handshake
  assign r_valid_o = (state_q == TransPending) & wen_q;
  assign b_valid_o = (state_q == TransPending) & ~wen_q;

  assign handshake    = (r_valid_o & r_ready_i) | (b_valid_o & b_ready_i);
  assign trans_done_o = handshake;

  // Word goes to the half picked by address bit 2 and the other half stays zero
  assign r_data_o = half_q ? {rdata_q, 32'h0} : {32'h0, rdata_q};

  // Last follows valid on a single-beat read
  assign r_last_o = r_valid_o;
  assign r_resp_o = RESP_OKAY;
  assign r_id_o   = id_q;

  assign b_resp_o = RESP_OKAY;
  assign b_id_o   = id_q;

endmodule

// File: axi2per_top.sv
module axi2per_top #(
  parameter int unsigned AXI_ID_WIDTH = 4,
  parameter int unsigned REG_NUM      = 16
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,

  // AW
  input  logic                    aw_valid_i,
  input  axi2per_pkg::axi_addr_t  aw_addr_i,
  input  logic [AXI_ID_WIDTH-1:0] aw_id_i,
  output logic                    aw_ready_o,

  // W
  input  logic                    w_valid_i,
  input  axi2per_pkg::axi_data_t  w_data_i,
  input  axi2per_pkg::axi_strb_t  w_strb_i,
  output logic                    w_ready_o,

  // AR
  input  logic                    ar_valid_i,
  input  axi2per_pkg::axi_addr_t  ar_addr_i,
  input  logic [AXI_ID_WIDTH-1:0] ar_id_i,
  output logic                    ar_ready_o,

  // R
  output logic                    r_valid_o,
  output axi2per_pkg::axi_data_t  r_data_o,
  output axi2per_pkg::axi_resp_t  r_resp_o,
  output logic                    r_last_o,
  output logic [AXI_ID_WIDTH-1:0] r_id_o,
  input  logic                    r_ready_i,

  // B
  output logic                    b_valid_o,
  output axi2per_pkg::axi_resp_t  b_resp_o,
  output logic [AXI_ID_WIDTH-1:0] b_id_o,
  input  logic                    b_ready_i
);

  import axi2per_pkg::*;

  // ********************
  // Peripheral bus
  // ********************
  logic       per_req;
  per_addr_t  per_add;
  logic       per_wen;
  logic [3:0] per_be;
  per_data_t  per_wdata;
  logic       per_gnt;
  logic       per_r_valid;
  per_data_t  per_r_rdata;

  // ********************
  // Transaction info
  // ********************
  logic                    trans_req;
  logic                    trans_wen;
  logic [AXI_ID_WIDTH-1:0] trans_id;
  axi_addr_t               trans_add;
  logic                    trans_done;

  // Input side, AXI requests to peripheral requests
  axi2per_req_channel #(
    .AXI_ID_WIDTH (AXI_ID_WIDTH)
  ) i_req_channel (
    .clk_i, .rst_ni,
    .aw_valid_i, .aw_addr_i, .aw_id_i, .aw_ready_o,
    .w_valid_i, .w_data_i, .w_strb_i, .w_ready_o,
    .ar_valid_i, .ar_addr_i, .ar_id_i, .ar_ready_o,
    .per_req_o    (per_req),
    .per_add_o    (per_add),
    .per_wen_o    (per_wen),
    .per_be_o     (per_be),
    .per_wdata_o  (per_wdata),
    .per_gnt_i    (per_gnt),
    .trans_req_o  (trans_req),
    .trans_wen_o  (trans_wen),
    .trans_id_o   (trans_id),
    .trans_add_o  (trans_add),
    .trans_done_i (trans_done)
  );

  // Local register bank as the peripheral target
  per_reg_bank #(
    .REG_NUM (REG_NUM)
  ) i_reg_bank (
    .clk_i, .rst_ni,
    .per_req_i     (per_req),
    .per_add_i     (per_add),
    .per_wen_i     (per_wen),
    .per_be_i      (per_be),
    .per_wdata_i   (per_wdata),
    .per_gnt_o     (per_gnt),
    .per_r_valid_o (per_r_valid),
    .per_r_rdata_o (per_r_rdata)
  );

  // Output side, peripheral answer to R or B
  axi2per_res_channel #(
    .AXI_ID_WIDTH (AXI_ID_WIDTH)
  ) i_res_channel (
    .clk_i, .rst_ni,
    .per_r_valid_i (per_r_valid),
    .per_r_rdata_i (per_r_rdata),
    .trans_req_i   (trans_req),
    .trans_wen_i   (trans_wen),
    .trans_id_i    (trans_id),
    .trans_add_i   (trans_add),
    .trans_done_o  (trans_done),
    .r_valid_o, .r_data_o, .r_resp_o, .r_last_o, .r_id_o, .r_ready_i,
    .b_valid_o, .b_resp_o, .b_id_o, .b_ready_i
  );

endmodule

// File: files.f
axi2per_pkg.sv
axi2per_req_channel.sv
per_reg_bank.sv
axi2per_res_channel.sv
axi2per_top.sv
axi2per_checker.sv
tb_axi2per.sv

// File: per_reg_bank.sv
module per_reg_bank #(
  parameter int unsigned REG_NUM = 16
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  // Request from the bridge
  input  logic                   per_req_i,
  input  axi2per_pkg::per_addr_t per_add_i,
  input  logic                   per_wen_i,
  input  logic [3:0]             per_be_i,
  input  axi2per_pkg::per_data_t per_wdata_i,
  output logic                   per_gnt_o,

  // Answer one cycle after the grant
  output logic                   per_r_valid_o,
  output axi2per_pkg::per_data_t per_r_rdata_o
);

  import axi2per_pkg::*;

  // Word index width, REG_NUM is a power of two
  localparam int unsigned IDX_W = $clog2(REG_NUM);

  per_data_t        regs_q [REG_NUM];
  per_data_t        rdata_q;
  logic             r_valid_q;
  logic [IDX_W-1:0] idx;
  logic             access;

  // Word index from the bits above the byte offset
  // Upper address bits are dropped, so the index wraps
  assign idx = per_add_i[IDX_W+1:2];

  // Busy while the previous answer is on the bus
  assign per_gnt_o = per_req_i & ~r_valid_q;
  assign access    = per_gnt_o;

  // ********************
  // Register array
  // ********************
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < REG_NUM; i++) begin
        regs_q[i] <= '0;
      end
      r_valid_q <= 1'b0;
    end else begin
      // One pulse per granted request
      r_valid_q <= access;
      if (access && !per_wen_i) begin
        // Byte enables select the bytes written
        for (int b = 0; b < 4; b++) begin
          if (per_be_i[b]) begin
            regs_q[idx][8*b +: 8] <= per_wdata_i[8*b +: 8];
          end
        end
      end
    end
  end

  // ********************
  // Read data
  // ********************
  always_ff @(posedge clk_i) begin
    if (access) begin
      // Writes answer with zero
      if (per_wen_i) begin
        rdata_q <= regs_q[idx];
      end else begin
        rdata_q <= '0;
      end
    end
  end

  assign per_r_valid_o = r_valid_q;
  assign per_r_rdata_o = rdata_q;

endmodule

// File: tb_axi2per.sv
module tb_axi2per;

  import axi2per_pkg::*;

  localparam int unsigned AXI_ID_WIDTH = 4;
  localparam int unsigned REG_NUM      = 16;
  localparam int unsigned RESET_CYCLES = 4;
  // Directed transactions plus 200 random ones
  localparam int unsigned TOTAL_TRANS  = 245;
  localparam logic [31:0] SEED         = 32'he52c_2d56;

  logic                    clk_i;
  logic                    rst_ni;
  logic                    aw_valid_i;
  axi_addr_t               aw_addr_i;
  logic [AXI_ID_WIDTH-1:0] aw_id_i;
  logic                    aw_ready_o;
  logic                    w_valid_i;
  axi_data_t               w_data_i;
  axi_strb_t               w_strb_i;
  logic                    w_ready_o;
  logic                    ar_valid_i;
  axi_addr_t               ar_addr_i;
  logic [AXI_ID_WIDTH-1:0] ar_id_i;
  logic                    ar_ready_o;
  logic                    r_valid_o;
  axi_data_t               r_data_o;
  axi_resp_t               r_resp_o;
  logic                    r_last_o;
  logic [AXI_ID_WIDTH-1:0] r_id_o;
  logic                    r_ready_i;
  logic                    b_valid_o;
  axi_resp_t               b_resp_o;
  logic [AXI_ID_WIDTH-1:0] b_id_o;
  logic                    b_ready_i;

  // Shadow registers and expected responses in issue order
  per_data_t               shadow [REG_NUM];
  logic                    exp_is_read [$];
  logic [AXI_ID_WIDTH-1:0] exp_id [$];
  axi_data_t               exp_data [$];

  int unsigned errors = 0;
  int unsigned test_errors_start = 0;
  int unsigned tests_passed = 0;
  int unsigned tests_failed = 0;
  logic        random_ready = 1'b0;
  logic [31:0] ready_rnd;
  logic [31:0] stim_rnd;

  axi2per_top #(
    .AXI_ID_WIDTH (AXI_ID_WIDTH),
    .REG_NUM      (REG_NUM)
  ) dut (
    .clk_i, .rst_ni,
    .aw_valid_i, .aw_addr_i, .aw_id_i, .aw_ready_o,
    .w_valid_i, .w_data_i, .w_strb_i, .w_ready_o,
    .ar_valid_i, .ar_addr_i, .ar_id_i, .ar_ready_o,
    .r_valid_o, .r_data_o, .r_resp_o, .r_last_o, .r_id_o, .r_ready_i,
    .b_valid_o, .b_resp_o, .b_id_o, .b_ready_i
  );

  always #2 clk_i = ~clk_i;

  // ********************
  // Reference model
  // ********************
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Word index wraps modulo the register count
  function automatic int unsigned word_index(input axi_addr_t addr);
    return (addr >> 2) % REG_NUM;
  endfunction

  // Strobes of the half picked by address bit 2 update the old word
  function automatic per_data_t merge_strobes(input per_data_t old, input axi_data_t data,
                                              input axi_strb_t strb, input logic half);
    per_data_t  lane;
    logic [3:0] be;
    per_data_t  res;
    lane = half ? data[63:32] : data[31:0];
    be   = half ? strb[7:4] : strb[3:0];
    res  = old;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = lane[8*b +: 8];
      end
    end
    return res;
  endfunction

  // Expected R word with the other half zero
  function automatic axi_data_t expected_read(input axi_addr_t addr);
    per_data_t word;
    word = shadow[word_index(addr)];
    return addr[2] ? {word, 32'h0} : {32'h0, word};
  endfunction

  task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                             input string what);
    if (got !== exp) begin
      $display("Mismatch at time %0t: %s, got %0h, expected %0h", $time, what, got, exp);
      errors++;
    end
  endtask

  // ********************
  // AXI master
  // ********************

  // Presents a write, a read or both at once and waits for the handshakes
  task automatic issue(input logic wr, input logic rd, input axi_addr_t waddr,
                       input axi_data_t wdata, input axi_strb_t strb,
                       input logic [AXI_ID_WIDTH-1:0] wid, input axi_addr_t raddr,
                       input logic [AXI_ID_WIDTH-1:0] rid);
    logic wr_left;
    logic rd_left;
    logic wr_hs;
    logic rd_hs;
    // Bridge serves AW+W before AR, so the model follows that order
    if (wr) begin
      shadow[word_index(waddr)] = merge_strobes(shadow[word_index(waddr)], wdata, strb,
                                                waddr[2]);
      exp_is_read.push_back(1'b0);
      exp_id.push_back(wid);
      exp_data.push_back('0);
    end
    if (rd) begin
      exp_is_read.push_back(1'b1);
      exp_id.push_back(rid);
      exp_data.push_back(expected_read(raddr));
    end
    @(negedge clk_i);
    aw_valid_i = wr;
    aw_addr_i  = waddr;
    aw_id_i    = wid;
    w_valid_i  = wr;
    w_data_i   = wdata;
    w_strb_i   = strb;
    ar_valid_i = rd;
    ar_addr_i  = raddr;
    ar_id_i    = rid;
    wr_left    = wr;
    rd_left    = rd;
    while (wr_left || rd_left) begin
      // Ready settles in the low phase
      #1;
      wr_hs = wr_left && aw_ready_o && w_ready_o;
      rd_hs = rd_left && ar_ready_o;
      @(negedge clk_i);
      if (wr_hs) begin
        wr_left    = 1'b0;
        aw_valid_i = 1'b0;
        w_valid_i  = 1'b0;
      end
      if (rd_hs) begin
        rd_left    = 1'b0;
        ar_valid_i = 1'b0;
      end
    end
  endtask

  task automatic axi_write(input axi_addr_t addr, input axi_data_t data, input axi_strb_t strb,
                           input logic [AXI_ID_WIDTH-1:0] id);
    issue(1'b1, 1'b0, addr, data, strb, id, '0, '0);
  endtask

  task automatic axi_read(input axi_addr_t addr, input logic [AXI_ID_WIDTH-1:0] id);
    issue(1'b0, 1'b1, '0, '0, '0, '0, addr, id);
  endtask

  // Drains the expected queue and prints one line for the test
  task automatic end_test(input string name);
    int unsigned cnt;
    cnt = 0;
    while (exp_is_read.size() != 0 && cnt < 200) begin
      @(negedge clk_i);
      cnt++;
    end
    if (exp_is_read.size() != 0) begin
      $display("Test %s: %0d responses never arrived", name, exp_is_read.size());
      errors++;
      exp_is_read.delete();
      exp_id.delete();
      exp_data.delete();
    end
    if (errors == test_errors_start) begin
      tests_passed++;
      $display("Test %s: pass", name);
    end else begin
      tests_failed++;
      $display("Test %s: fail with %0d errors", name, errors - test_errors_start);
    end
    test_errors_start = errors;
  endtask

  // ********************
  // Ready lines and compare
  // ********************
  always @(negedge clk_i) begin
    if (random_ready) begin
      ready_rnd = xorshift32(ready_rnd);
      r_ready_i = ready_rnd[0];
      b_ready_i = ready_rnd[1];
    end else begin
      r_ready_i = 1'b1;
      b_ready_i = 1'b1;
    end
  end

  // Every R or B handshake takes the oldest expected response
  always @(posedge clk_i) begin
    if (rst_ni && ((r_valid_o && r_ready_i) || (b_valid_o && b_ready_i))) begin
      if (exp_is_read.size() == 0) begin
        $display("Response at time %0t with no request outstanding", $time);
        errors++;
      end else begin
        check_value(r_valid_o, exp_is_read[0], "R versus B channel");
        if (r_valid_o) begin
          check_value(r_data_o, exp_data[0], "R data");
          check_value(r_id_o, exp_id[0], "R id");
          check_value(r_resp_o, RESP_OKAY, "R resp");
          check_value(r_last_o, 1'b1, "R last");
        end else begin
          check_value(b_id_o, exp_id[0], "B id");
          check_value(b_resp_o, RESP_OKAY, "B resp");
        end
        void'(exp_is_read.pop_front());
        void'(exp_id.pop_front());
        void'(exp_data.pop_front());
      end
    end
  end

  // Watchdog sized from the transaction count
  initial begin
    repeat (RESET_CYCLES + TOTAL_TRANS * 40) @(posedge clk_i);
    $display("Watchdog expired, the run did not finish in time");
    $display("TB FAILED");
    $finish;
  end

  // ********************
  // Test sequence
  // ********************
  initial begin : main
    axi_addr_t               addr;
    axi_data_t               data;
    axi_strb_t               strb;
    logic [AXI_ID_WIDTH-1:0] id;
    clk_i      = 1'b0;
    rst_ni     = 1'b0;
    aw_valid_i = 1'b0;
    aw_addr_i  = '0;
    aw_id_i    = '0;
    w_valid_i  = 1'b0;
    w_data_i   = '0;
    w_strb_i   = '0;
    ar_valid_i = 1'b0;
    ar_addr_i  = '0;
    ar_id_i    = '0;
    r_ready_i  = 1'b1;
    b_ready_i  = 1'b1;
    stim_rnd   = SEED;
    ready_rnd  = xorshift32(SEED);
    for (int i = 0; i < REG_NUM; i++) begin
      shadow[i] = '0;
    end
    repeat (RESET_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    // All registers start at zero
    for (int i = 0; i < REG_NUM; i++) begin
      axi_read(axi_addr_t'(4 * i), AXI_ID_WIDTH'(i));
    end
    end_test("reset_values");

    // Full words in both halves
    axi_write(32'h10, 64'hdead_beef_1234_5678, 8'hff, 4'h3);
    axi_write(32'h14, 64'hcafe_f00d_0bad_c0de, 8'hff, 4'h9);
    axi_write(32'h18, 64'h0000_0000_a5a5_5a5a, 8'h0f, 4'h1);
    axi_write(32'h1c, 64'h7654_3210_0000_0000, 8'hf0, 4'he);
    axi_read(32'h10, 4'h2);
    axi_read(32'h14, 4'h7);
    axi_read(32'h18, 4'hc);
    axi_read(32'h1c, 4'h5);
    end_test("full_words");

    // Only strobes of the selected half count
    axi_write(32'h20, 64'h1111_2222_3333_4444, 8'h05, 4'h4);
    axi_write(32'h24, 64'h5566_7788_99aa_bbcc, 8'h60, 4'h6);
    axi_write(32'h28, 64'hffff_ffff_eeee_eeee, 8'hf2, 4'h8);
    axi_write(32'h2c, 64'h0123_4567_89ab_cdef, 8'h0c, 4'ha);
    axi_read(32'h20, 4'h0);
    axi_read(32'h24, 4'h1);
    axi_read(32'h28, 4'h2);
    axi_read(32'h2c, 4'h3);
    end_test("partial_strobes");

    // AW, W and AR in the same cycle
    issue(1'b1, 1'b1, 32'h30, 64'h0000_0000_abcd_ef01, 8'hff, 4'hb, 32'h30, 4'hd);
    issue(1'b1, 1'b1, 32'h34, 64'h1357_9bdf_0000_0000, 8'hff, 4'h2, 32'h34, 4'hf);
    end_test("write_before_read");

    // Random traffic with random ready back-pressure
    random_ready = 1'b1;
    for (int n = 0; n < 200; n++) begin
      stim_rnd = xorshift32(stim_rnd);
      // Eight bits of address also cross the wrap point
      addr = {24'h0, stim_rnd[7:2], 2'b00};
      id   = stim_rnd[11:8];
      strb = stim_rnd[23:16];
      stim_rnd = xorshift32(stim_rnd);
      data[31:0] = stim_rnd;
      stim_rnd = xorshift32(stim_rnd);
      data[63:32] = stim_rnd;
      if (stim_rnd[12]) begin
        axi_write(addr, data, strb, id);
      end else begin
        axi_read(addr, id);
      end
    end
    end_test("random_backpressure");
    random_ready = 1'b0;

    // Addresses past the bank alias the low registers
    axi_write(axi_addr_t'(4 * (REG_NUM + 1)), 64'h600d_cafe_0000_0000, 8'hff, 4'h1);
    axi_write(axi_addr_t'(4 * (2 * REG_NUM + 2)), 64'h0000_0000_1ee7_0042, 8'hff, 4'h2);
    axi_write(axi_addr_t'(4 * (3 * REG_NUM + 3)), 64'hbeef_0000_0000_0000, 8'hc0, 4'h3);
    axi_write(32'h0000_1000, 64'h0000_0000_0f0f_f0f0, 8'h0f, 4'h4);
    axi_read(32'h4, 4'h5);
    axi_read(32'h8, 4'h6);
    axi_read(32'hc, 4'h7);
    axi_read(axi_addr_t'(4 * (5 * REG_NUM + 1)), 4'h8);
    axi_read(32'h0, 4'h9);
    end_test("address_wrap");

    check_value(dut.i_checker.fail_count, 0, "bound assertion failures");
    $display("Tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule
